/* build.f */
frv_pkg.sv
frv_core_fetch_buffer.sv
frv_pipeline_register.sv
frv_core_fetch.sv
frv_pipeline.sv
tb_clock_gen.sv
tb_frv_pipeline.sv

/* tb_frv_pipeline.sv */
/*
 * Directed tests of the fetch front end through its top level.
 * Memory answers each accepted request one cycle later with addr ^ 0x13579BDF.
 * Inputs change 2 ns after the rising edge, outputs are sampled on the falling
 * edge. Delivered PCs are checked as one running sequence across all tests.
 */
`timescale 1ns/1ps

module tb_frv_pipeline;

    import frv_pkg::*;

    localparam int    CLK_PERIOD      = 40;                   // ns
    localparam word_t INSTR_XOR       = 32'h1357_9BDF;        // Memory data rule
    localparam addr_t REDIR_TARGET    = 32'h8000_1000;        // Redirect destination
    localparam int    TEST_CYCLES     = 10 + 30 + 60 + 90 + 45 + 35; // Per test, in cycles
    localparam int    WATCHDOG_CYCLES = TEST_CYCLES * 4;

    logic        clk;
    logic        rst_n;
    logic        imem_cen;
    logic        imem_stall;
    addr_t       imem_addr;
    word_t       imem_rdata;
    logic        imem_error;
    logic        cf_req;
    addr_t       cf_target;
    logic        cf_ack;
    fetch_pkt_t  s1_pkt;
    logic        s1_valid;
    logic        s1_busy;

    integer      seed = 32'hb5e0;           // $random seed
    logic [31:0] mem_rnd;
    logic        stall_en;                  // Random imem_stall on
    addr_t       err_addrs[$];              // Addresses answered with error
    fetch_pkt_t  rx_q[$];                   // Packets taken by decode
    int          rd_idx;                    // Next rx_q entry to check
    addr_t       next_pc;                   // Expected PC of that entry
    int          err_count;
    int          err_pkts;                  // Checked packets with error set
    int          tests_passed;
    int          tests_failed;
    logic        mem_accept;                // Request taken at next edge
    addr_t       mem_addr;
    logic        held_prev;                 // s1 held over the last edge
    fetch_pkt_t  held_pkt;

    tb_clock_gen clk_gen_i (
        .clk   (clk  ),
        .rst_n (rst_n)
    );

    frv_pipeline dut_i (
        .g_clk      (clk       ),
        .rst_n      (rst_n     ),
        .imem_cen   (imem_cen  ),
        .imem_stall (imem_stall),
        .imem_addr  (imem_addr ),
        .imem_rdata (imem_rdata),
        .imem_error (imem_error),
        .cf_req     (cf_req    ),
        .cf_target  (cf_target ),
        .cf_ack     (cf_ack    ),
        .s1_pkt     (s1_pkt    ),
        .s1_valid   (s1_valid  ),
        .s1_busy    (s1_busy   )
    );

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    task automatic compare(input string name, input logic [95:0] actual,
                           input logic [95:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
            err_count++;
        end
    endtask

    function automatic logic is_error_addr(input addr_t addr);
        logic hit;
        hit = 1'b0;
        foreach (err_addrs[i]) begin
            if (err_addrs[i] == addr) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Memory model, one cycle response
    always @(negedge clk) begin
        mem_accept = imem_cen && !imem_stall;
        mem_addr   = imem_addr;
    end

    always @(posedge clk) begin
        #2;
        if (mem_accept === 1'b1) begin
            imem_rdata = mem_addr ^ INSTR_XOR;
            imem_error = is_error_addr(mem_addr);
        end else begin
            imem_rdata = '0;
            imem_error = 1'b0;
        end
        if (stall_en) begin
            mem_rnd    = $random(seed);
            imem_stall = (mem_rnd[1:0] == 2'b00);  // About one cycle in four
        end else begin
            imem_stall = 1'b0;
        end
    end

    // Decode side monitor and hold check
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (held_prev) begin
                compare("s1_valid", s1_valid, 1'b1);
                compare("s1_pkt", s1_pkt, held_pkt);
            end
            held_prev = s1_valid && s1_busy && !cf_ack; // Ack flushes FD
            held_pkt  = s1_pkt;
            if (s1_valid && !s1_busy) begin
                rx_q.push_back(s1_pkt);
            end
        end
    end

    task automatic wait_packets(input int total);
        while (rx_q.size() < total) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Next n packets must continue the PC sequence
    task automatic check_packets(input int n);
        fetch_pkt_t pkt;
        wait_packets(rd_idx + n);
        repeat (n) begin
            pkt = rx_q[rd_idx];
            compare("s1_pkt.pc", pkt.pc, next_pc);
            compare("s1_pkt.instr", pkt.instr, next_pc ^ INSTR_XOR);
            compare("s1_pkt.error", pkt.error, is_error_addr(next_pc));
            if (pkt.error) begin
                err_pkts++;
            end
            rd_idx++;
            next_pc = next_pc + 32'd4;              // One word per packet
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (err_count == err_start) begin
            tests_passed++;
            $display("test %-20s passed", name);
        end else begin
            tests_failed++;
            $display("test %-20s failed with %0d errors", name, err_count - err_start);
        end
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------

    task automatic test_reset_state();
        int err_start;
        err_start = err_count;
        @(negedge clk);
        while (rst_n !== 1'b1) begin
            compare("s1_valid", s1_valid, 1'b0);
            compare("cf_ack", cf_ack, 1'b0);
            compare("imem_cen", imem_cen, 1'b0);
            @(negedge clk);
        end
        compare("s1_valid", s1_valid, 1'b0);       // First cycle out of reset
        compare("cf_ack", cf_ack, 1'b0);
        @(negedge clk);                             // First full cycle after release
        compare("imem_cen", imem_cen, 1'b1);
        compare("imem_addr", imem_addr, FRV_PC_RESET_VALUE);
        finish_test("reset_state", err_start);
    endtask

    task automatic test_sequential_fetch();
        int err_start;
        err_start = err_count;
        check_packets(20);                          // Starts at the reset PC
        finish_test("sequential_fetch", err_start);
    endtask

    task automatic test_memory_stalls();
        int err_start;
        err_start = err_count;
        stall_en = 1'b1;
        check_packets(20);
        stall_en = 1'b0;
        finish_test("memory_stalls", err_start);
    endtask

    task automatic test_decode_backpressure();
        int          err_start;
        int          span_left;
        logic [31:0] r;
        err_start = err_count;
        span_left = 0;
        while (rx_q.size() < rd_idx + 20) begin
            @(posedge clk);
            #2;
            if (span_left == 0) begin
                r         = $random(seed);
                s1_busy   = !s1_busy;               // Alternate busy and free spans
                span_left = 1 + r[2:0];
            end
            span_left--;
        end
        s1_busy = 1'b0;
        check_packets(20);
        finish_test("decode_backpressure", err_start);
    endtask

    task automatic test_redirect();
        int err_start;
        int ack_idx;
        err_start = err_count;
        @(posedge clk);
        #2;
        cf_req    = 1'b1;
        cf_target = REDIR_TARGET;
        @(negedge clk);
        while (cf_ack !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        cf_req  = 1'b0;
        ack_idx = rx_q.size();                      // Includes the ack cycle transfer
        check_packets(ack_idx - rd_idx);            // Old path, still in order
        @(negedge clk);
        compare("cf_ack", cf_ack, 1'b0);            // Single cycle pulse
        next_pc = REDIR_TARGET;
        check_packets(12);
        finish_test("redirect", err_start);
    endtask

    task automatic test_fetch_error();
        int err_start;
        int pkt_start;
        err_start = err_count;
        pkt_start = err_pkts;
        err_addrs.push_back(next_pc + 32'd48);      // Well ahead of fetch
        err_addrs.push_back(next_pc + 32'd60);
        check_packets(20);
        compare("error packet count", err_pkts - pkt_start, 2);
        err_addrs.delete();
        finish_test("fetch_error", err_start);
    endtask

    // ------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------

    initial begin
        imem_stall   = 1'b0;
        imem_rdata   = '0;
        imem_error   = 1'b0;
        cf_req       = 1'b0;
        cf_target    = '0;
        s1_busy      = 1'b0;
        stall_en     = 1'b0;
        held_prev    = 1'b0;
        rd_idx       = 0;
        next_pc      = FRV_PC_RESET_VALUE;
        err_count    = 0;
        err_pkts     = 0;
        tests_passed = 0;
        tests_failed = 0;

        test_reset_state();
        test_sequential_fetch();
        test_memory_stalls();
        test_decode_backpressure();
        test_redirect();
        test_fetch_error();

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("TIMEOUT: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset. 40 ns period, clock starts low.
 * rst_n is held low over two rising edges and released 2 ns after the second.
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,                       // Testbench clock
    output logic rst_n                      // Async reset, active low
);

    localparam int HALF_PERIOD = 20;        // ns

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;                       // Same offset as other stimulus
    end

endmodule

/* frv_pipeline.sv */
/*
 * Front end of the RV32 pipeline: fetch stage and FD register.
 * Decode and later stages sit outside, and drive cf_req/cf_target until
 * cf_ack. Only 32-bit reads are made on imem; there is no write path.
 */
`timescale 1ns/1ps

module frv_pipeline (
    input  logic                g_clk,      // Global clock
    input  logic                rst_n,      // Async reset, active low

    // Instruction memory
    output logic                imem_cen,   // Chip enable
    input  logic                imem_stall, // Memory stall
    output frv_pkg::addr_t      imem_addr,  // Read address
    input  frv_pkg::word_t      imem_rdata, // Read data
    input  logic                imem_error, // Read error

    // Control flow change
    input  logic                cf_req,     // Redirect request
    input  frv_pkg::addr_t      cf_target,  // Redirect address
    output logic                cf_ack,     // Redirect taken

    // Decode side
    output frv_pkg::fetch_pkt_t s1_pkt,     // Packet to decode
    output logic                s1_valid,   // s1_pkt valid
    input  logic                s1_busy     // Decode busy
);

    import frv_pkg::*;

    // ------------------------------------------------------------------
    // Fetch to FD wires
    // ------------------------------------------------------------------

    fetch_pkt_t s0_pkt;                     // Fetch output packet
    logic       s0_valid;                   // s0_pkt valid
    logic       s0_busy;                    // FD register full
    logic       fd_flush;                   // Clear FD on redirect

    // ------------------------------------------------------------------
    // Fetch stage
    // ------------------------------------------------------------------

    frv_core_fetch i_core_fetch (
        .g_clk      (g_clk     ),
        .rst_n      (rst_n     ),
        .cf_req     (cf_req    ), // Redirect request
        .cf_target  (cf_target ),
        .cf_ack     (cf_ack    ),
        .fd_flush   (fd_flush  ),
        .imem_cen   (imem_cen  ),
        .imem_stall (imem_stall),
        .imem_addr  (imem_addr ),
        .imem_rdata (imem_rdata),
        .imem_error (imem_error),
        .s0_pkt     (s0_pkt    ), // To FD register
        .s0_valid   (s0_valid  ),
        .s0_busy    (s0_busy   )
    );

    // ------------------------------------------------------------------
    // FD pipeline register
    // ------------------------------------------------------------------

    frv_pipeline_register #(
        .RLEN (FETCH_PKT_W)
    ) i_pipereg_fd (
        .g_clk   (g_clk   ),
        .rst_n   (rst_n   ),
        .i_data  (s0_pkt  ), // Whole fetch packet
        .i_valid (s0_valid),
        .o_busy  (s0_busy ),
        .flush   (fd_flush),
        .o_data  (s1_pkt  ),
        .o_valid (s1_valid),
        .i_busy  (s1_busy )  // Decode back-pressure
    );

endmodule

/* frv_core_fetch.sv */
/*
 * Fetch stage. Keeps at most one imem request outstanding and only issues
 * when the buffer can take its response. A redirect waits for any stalled
 * request to be accepted first, then requests cf_target. Memory errors are
 * passed on with the word and do not stop fetching.
 */
`timescale 1ns/1ps

module frv_core_fetch (
    input  logic                g_clk,      // Global clock
    input  logic                rst_n,      // Async reset, active low
    input  logic                cf_req,     // Control flow change request
    input  frv_pkg::addr_t      cf_target,  // New fetch address
    output logic                cf_ack,     // Target request accepted
    output logic                fd_flush,   // Flush the FD register
    output logic                imem_cen,   // Memory request
    input  logic                imem_stall, // Memory not accepting
    output frv_pkg::addr_t      imem_addr,  // Request address
    input  frv_pkg::word_t      imem_rdata, // Response word
    input  logic                imem_error, // Response error
    output frv_pkg::fetch_pkt_t s0_pkt,     // Packet to FD register
    output logic                s0_valid,   // s0_pkt valid
    input  logic                s0_busy     // FD register full
);

    import frv_pkg::*;

    // ------------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------------

    fetch_state_t state;         // Request FSM
    fetch_state_t state_nxt;
    addr_t        fetch_pc;      // Address presented on imem
    logic         fetch_cf;      // fetch_pc is the redirect target
    logic         accept;        // Request taken by memory
    logic [2:0]   occ_nxt;       // Buffer entries next cycle
    logic [2:0]   occ_req;       // Plus a request accepted now
    logic         space_ok;      // Room for one more response
    logic         go_req;        // Present a request next cycle

    // Response side
    logic         rsp_pend;      // Response arrives this cycle
    logic         rsp_discard;   // That response is off the old path
    addr_t        rsp_pc;        // PC of the outstanding request
    fetch_pkt_t   rsp_pkt;
    logic         push;
    logic         pop;
    logic         buf_valid;
    logic [1:0]   buf_count;

    assign imem_cen  = (state == REQ);
    assign imem_addr = fetch_pc;
    assign accept    = imem_cen && !imem_stall;

    assign cf_ack   = accept && fetch_cf;          // One cycle, on target accept
    assign fd_flush = cf_ack;

    // Occupancy seen by the request made next cycle
    assign occ_nxt  = cf_ack ? 3'd0 : ({1'b0, buf_count} + {2'b00, push} - {2'b00, pop});
    assign occ_req  = occ_nxt + {2'b00, accept};
    assign space_ok = (occ_req < FBUF_DEPTH);

    // Flush on ack frees the buffer, so a redirect never waits for space
    assign go_req = space_ok || (cf_req && !cf_ack);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE       : state_nxt = REQ;          // First request after reset
            REQ        : begin
                if (accept) begin
                    state_nxt = go_req ? REQ : WAIT_SPACE;
                end
            end
            WAIT_SPACE : begin
                if (go_req) begin
                    state_nxt = REQ;
                end
            end
            default    : state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            fetch_pc <= FRV_PC_RESET_VALUE;
            fetch_cf <= 1'b0;
        end else begin
            state <= state_nxt;
            // Address may only move when no request is held by a stall
            if (!imem_cen || accept) begin
                if (cf_req && !cf_ack) begin
                    fetch_pc <= cf_target;         // Switch path
                    fetch_cf <= 1'b1;
                end else if (accept) begin
                    fetch_pc <= fetch_pc + PC_STEP;
                    fetch_cf <= 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Response tracking
    // ------------------------------------------------------------------

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_pend    <= 1'b0;
            rsp_discard <= 1'b0;
        end else begin
            rsp_pend    <= accept;
            rsp_discard <= accept && cf_req && !fetch_cf; // Known stale already
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            rsp_pc <= fetch_pc;
        end
    end

    assign rsp_pkt = '{error: imem_error, pc: rsp_pc, instr: imem_rdata};

    // Response landing on the ack cycle belongs to the old path
    assign push = rsp_pend && !rsp_discard && !cf_ack;
    assign pop  = s0_valid && !s0_busy;

    assign s0_valid = buf_valid && !cf_ack;

    frv_core_fetch_buffer i_fetch_buffer (
        .g_clk     (g_clk    ),
        .rst_n     (rst_n    ),
        .flush     (cf_ack   ), // Drop old path words
        .push      (push     ),
        .push_pkt  (rsp_pkt  ),
        .pop       (pop      ),
        .out_valid (buf_valid),
        .out_pkt   (s0_pkt   ),
        .count     (buf_count)
    );

    // Memory sees the same request until it takes it
    a_imem_hold : assert property (@(posedge g_clk) disable iff (!rst_n)
        imem_cen && imem_stall |=> imem_cen && $stable(imem_addr))
        else $error("imem request changed during stall");

endmodule

/* frv_pipeline_register.sv */
/*
 * One stage-to-stage register slice with valid/busy flow control.
 * It reloads when empty or when its item leaves in the same cycle, so
 * o_busy depends on i_busy combinationally. flush drops the held item
 * and any item offered in the same cycle.
 */
`timescale 1ns/1ps

module frv_pipeline_register #(
    parameter int RLEN = 32                 // Item width
) (
    input  logic            g_clk,          // Global clock
    input  logic            rst_n,          // Async reset, active low
    input  logic [RLEN-1:0] i_data,         // Item from stage N
    input  logic            i_valid,        // i_data valid
    output logic            o_busy,         // Stage N must hold
    input  logic            flush,          // Drop the held item
    output logic [RLEN-1:0] o_data,         // Item to stage N+1
    output logic            o_valid,        // o_data valid
    input  logic            i_busy          // Stage N+1 busy
);

    // ------------------------------------------------------------------
    // Flow control
    // ------------------------------------------------------------------

    logic load;                             // Slot free this cycle

    assign load   = !o_valid || !i_busy;    // Empty, or item leaving
    assign o_busy = o_valid && i_busy;

    // ------------------------------------------------------------------
    // Slice
    // ------------------------------------------------------------------

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
        end else if (flush) begin
            o_valid <= 1'b0;                // Flush beats load
        end else if (load) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (load && i_valid && !flush) begin
            o_data <= i_data;
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    // Next stage can rely on a held item not moving
    a_hold_data : assert property (@(posedge g_clk) disable iff (!rst_n)
        o_valid && i_busy && !flush |=> $stable(o_data))
        else $error("pipeline register data changed while held");

endmodule

/* frv_core_fetch_buffer.sv */
/*
 * Two-entry FIFO of fetch packets. An empty FIFO shows the word being
 * pushed on its output in the same cycle, so a single word passes through.
 * flush wins over push and pop. Pushing while full is not supported.
 */
`timescale 1ns/1ps

module frv_core_fetch_buffer (
    input  logic                g_clk,     // Global clock
    input  logic                rst_n,     // Async reset, active low
    input  logic                flush,     // Drop every entry
    input  logic                push,      // Write a packet
    input  frv_pkg::fetch_pkt_t push_pkt,  // Packet to write
    input  logic                pop,       // Consume the head packet
    output logic                out_valid, // Head packet present
    output frv_pkg::fetch_pkt_t out_pkt,   // Head packet
    output logic [1:0]          count      // Entries held
);

    import frv_pkg::*;

    // ------------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------------

    fetch_pkt_t            mem [FBUF_DEPTH]; // Packet storage
    logic [FBUF_PTR_W-1:0] wr_ptr;           // Next slot to write
    logic [FBUF_PTR_W-1:0] rd_ptr;           // Head slot
    logic                  empty;            // Nothing stored
    logic                  wr_en;            // Push lands in storage
    logic                  rd_en;            // Pop frees a stored entry

    assign empty = (count == 2'd0);

    // A word pushed and popped while empty never touches storage
    assign wr_en = push && !(empty && pop);
    assign rd_en = pop && !empty;

    assign out_valid = !empty || push;                // Bypass when empty
    assign out_pkt   = empty ? push_pkt : mem[rd_ptr];

    // ------------------------------------------------------------------
    // Pointer and occupancy update
    // ------------------------------------------------------------------

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= 2'd0;
        end else if (flush) begin
            wr_ptr <= '0;                             // Flush beats push
            rd_ptr <= '0;
            count  <= 2'd0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;              // Wraps at depth 2
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {1'b0, wr_en} - {1'b0, rd_en};
        end
    end

    always_ff @(posedge g_clk) begin
        if (wr_en && !flush) begin
            mem[wr_ptr] <= push_pkt;                  // Payload only
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    // Fetch reserves room before it issues a request
    a_no_push_full : assert property (@(posedge g_clk) disable iff (!rst_n)
        push && !flush |-> count < FBUF_DEPTH)
        else $error("fetch buffer pushed while full");

    // Stage behind may only take a word that exists
    a_no_pop_empty : assert property (@(posedge g_clk) disable iff (!rst_n)
        pop |-> !empty || push)
        else $error("fetch buffer popped while empty");

endmodule

/* frv_pkg.sv */
/*
 * Shared widths, types and constants of the RV32 fetch front end.
 * Only 32-bit instructions are fetched, so the PC always steps by 4.
 * The fetch buffer depth is fixed at 2 and its pointers are sized from it.
 */
package frv_pkg;

    // ------------------------------------------------------------------
    // Data path widths
    // ------------------------------------------------------------------

    localparam int XLEN = 32;                     // Data path width

    typedef logic [XLEN-1:0] word_t;              // Instruction or memory word
    typedef logic [XLEN-1:0] addr_t;              // Byte address or PC

    // ------------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------------

    localparam addr_t FRV_PC_RESET_VALUE = 32'h8000_0000; // PC after reset
    localparam addr_t PC_STEP            = 32'd4;         // One 32-bit instruction

    // ------------------------------------------------------------------
    // Fetch packet
    // ------------------------------------------------------------------

    // Unit carried from fetch through the FD register
    typedef struct packed {
        logic  error;                             // Memory error on this word
        addr_t pc;                                // Address the word came from
        word_t instr;                             // Fetched instruction
    } fetch_pkt_t;

    localparam int FETCH_PKT_W = $bits(fetch_pkt_t); // 65 bits

    // ------------------------------------------------------------------
    // Fetch buffer and request FSM
    // ------------------------------------------------------------------

    localparam int FBUF_DEPTH = 2;                // Fetch buffer entries
    localparam int FBUF_PTR_W = $clog2(FBUF_DEPTH); // Buffer pointer width

    typedef enum logic [1:0] {
        IDLE,                                     // Leaving reset
        REQ,                                      // Request on imem
        WAIT_SPACE                                // No room for another word
    } fetch_state_t;

endpackage
